// ==== rtl/rs_config.svh ====
`ifndef RS_CONFIG_SVH
`define RS_CONFIG_SVH

// station size, must stay a power of two for the round-robin wrap
`define RS_DEPTH 16

// physical register tag width
`define RS_TAG_W 8

// operand and result width
`define RS_XLEN 32

// broadcast buses: arithmetic and load
`define RS_NUM_WAKEUP 2

`endif

// ==== rtl/rs_pkg.sv ====
`include "rs_config.svh"

package rs_pkg;

    typedef logic [`RS_TAG_W-1:0] tag_t;
    typedef logic [`RS_XLEN-1:0] word_t;
    typedef logic [$clog2(`RS_DEPTH)-1:0] idx_t;

    typedef enum logic [3:0] {
        DIV  = 4'd0,
        DIVU = 4'd1,
        REM  = 4'd2,
        REMU = 4'd3
    } div_op_t;

    typedef struct packed {
        logic  ready;
        tag_t  tag;
        word_t data;
    } operand_t;

    typedef struct packed {
        div_op_t  op;
        tag_t     dest;
        operand_t src1;
        operand_t src2;
    } rs_entry_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        word_t data;
    } wakeup_t;

    typedef struct packed {
        div_op_t op;
        tag_t    dest;
        word_t   a;
        word_t   b;
    } issue_t;

    // take data from any broadcast whose tag this operand waits on
    function automatic operand_t wake_operand(operand_t src,
                                              wakeup_t [`RS_NUM_WAKEUP-1:0] bus);
        operand_t res;
        res = src;
        for (int b = 0; b < `RS_NUM_WAKEUP; b++) begin
            if (!src.ready && bus[b].valid && bus[b].tag == src.tag) begin
                res.ready = 1'b1;
                res.data  = bus[b].data;
            end
        end
        return res;
    endfunction

endpackage

// ==== rtl/rs_write_if.sv ====
`timescale 1ns/1ps
`include "rs_config.svh"

interface rs_write_if import rs_pkg::*; ();

    logic [`RS_DEPTH-1:0] busy_mask; // occupied slots
    logic                 wr_en;
    idx_t                 wr_index;  // always a free slot
    rs_entry_t            wr_entry;

    modport dispatch (
        input  busy_mask,
        output wr_en,
        output wr_index,
        output wr_entry
    );

    modport array (
        output busy_mask,
        input  wr_en,
        input  wr_index,
        input  wr_entry
    );

endinterface

// ==== rtl/rs_issue_if.sv ====
`timescale 1ns/1ps
`include "rs_config.svh"

interface rs_issue_if import rs_pkg::*; ();

    logic [`RS_DEPTH-1:0] ready_mask;  // busy with both operands ready
    logic                 grant;       // slot leaves the array this edge
    idx_t                 grant_index;
    rs_entry_t            grant_entry; // entry at grant_index

    modport array (
        output ready_mask,
        output grant_entry,
        input  grant,
        input  grant_index
    );

    modport select (
        input  ready_mask,
        input  grant_entry,
        output grant,
        output grant_index
    );

endinterface

// ==== rtl/rs_dispatch.sv ====
`timescale 1ns/1ps
`include "rs_config.svh"

module rs_dispatch import rs_pkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          disp_valid,
    input  div_op_t                       disp_op,
    input  tag_t                          disp_dest,
    input  operand_t                      disp_src1,
    input  operand_t                      disp_src2,
    input  wakeup_t [`RS_NUM_WAKEUP-1:0]  wakeup,
    output logic                          disp_ready,
    rs_write_if.dispatch                  wr
);

    logic [`RS_DEPTH-1:0] free_mask;
    logic                 any_free;
    idx_t                 free_idx;
    logic                 dup_tag;

    assign free_mask = ~wr.busy_mask;
    assign any_free  = |free_mask;

    // lowest free slot wins
    always_comb begin
        free_idx = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (free_mask[i]) begin
                free_idx = idx_t'(i);
            end
        end
    end

    assign disp_ready  = any_free;
    assign wr.wr_en    = disp_valid && any_free;
    assign wr.wr_index = free_idx;

    // same-cycle bypass from the broadcast buses
    always_comb begin
        wr.wr_entry.op   = disp_op;
        wr.wr_entry.dest = disp_dest;
        wr.wr_entry.src1 = wake_operand(disp_src1, wakeup);
        wr.wr_entry.src2 = wake_operand(disp_src2, wakeup);
    end

    always_comb begin
        dup_tag = 1'b0;
        for (int a = 0; a < `RS_NUM_WAKEUP; a++) begin
            for (int b = a + 1; b < `RS_NUM_WAKEUP; b++) begin
                if (wakeup[a].valid && wakeup[b].valid && wakeup[a].tag == wakeup[b].tag) begin
                    dup_tag = 1'b1;
                end
            end
        end
    end

    // producers never broadcast one tag twice in a cycle
    a_unique_tags: assert property (@(posedge clk) disable iff (reset) !dup_tag)
        else $error("rs_dispatch: duplicate broadcast tag");

endmodule

// ==== rtl/rs_entry_array.sv ====
`timescale 1ns/1ps
`include "rs_config.svh"

module rs_entry_array import rs_pkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  wakeup_t [`RS_NUM_WAKEUP-1:0]  wakeup,
    rs_write_if.array                     wr,
    rs_issue_if.array                     iss
);

    rs_entry_t            entries [`RS_DEPTH];
    logic [`RS_DEPTH-1:0] busy;

    assign wr.busy_mask    = busy;
    assign iss.grant_entry = entries[iss.grant_index];

    always_comb begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            iss.ready_mask[i] = busy[i] && entries[i].src1.ready && entries[i].src2.ready;
        end
    end

    // write sets, grant clears; they never hit the same slot
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy <= '0;
        end else begin
            if (wr.wr_en) begin
                busy[wr.wr_index] <= 1'b1;
            end
            if (iss.grant) begin
                busy[iss.grant_index] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (busy[i]) begin
                entries[i].src1 <= wake_operand(entries[i].src1, wakeup); // tag match capture
                entries[i].src2 <= wake_operand(entries[i].src2, wakeup);
            end
        end
        if (wr.wr_en) begin
            entries[wr.wr_index] <= wr.wr_entry; // target slot is idle
        end
    end

    a_write_free: assert property (@(posedge clk) disable iff (reset)
        wr.wr_en |-> !busy[wr.wr_index])
        else $error("rs_entry_array: write to busy slot %0d", wr.wr_index);

    a_grant_ready: assert property (@(posedge clk) disable iff (reset)
        iss.grant |-> iss.ready_mask[iss.grant_index])
        else $error("rs_entry_array: grant of slot %0d not ready", iss.grant_index);

endmodule

// ==== rtl/rs_issue_select.sv ====
`timescale 1ns/1ps
`include "rs_config.svh"

module rs_issue_select import rs_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    rs_issue_if.select  iss,
    output logic        issue_valid,
    input  logic        issue_ready,
    output issue_t      issue_data
);

    idx_t rr_ptr;  // first slot looked at
    idx_t pick;
    logic found;
    logic load_en;

    // scan from rr_ptr and wrap through the array
    always_comb begin
        idx_t slot;
        found = 1'b0;
        pick  = rr_ptr;
        for (int k = 0; k < `RS_DEPTH; k++) begin
            slot = idx_t'(rr_ptr + idx_t'(k));
            if (!found && iss.ready_mask[slot]) begin
                found = 1'b1;
                pick  = slot;
            end
        end
    end

    assign load_en         = !issue_valid || issue_ready; // empty or draining
    assign iss.grant       = found && load_en;
    assign iss.grant_index = pick;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rr_ptr      <= '0;
            issue_valid <= 1'b0;
        end else begin
            if (iss.grant) begin
                rr_ptr <= idx_t'(pick + 1'b1);
            end
            if (load_en) begin
                issue_valid <= found;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (iss.grant) begin
            issue_data.op   <= iss.grant_entry.op;
            issue_data.dest <= iss.grant_entry.dest;
            issue_data.a    <= iss.grant_entry.src1.data;
            issue_data.b    <= iss.grant_entry.src2.data;
        end
    end

endmodule

// ==== rtl/div_rs.sv ====
`timescale 1ns/1ps
`include "rs_config.svh"

module div_rs import rs_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    disp_valid,
    input  div_op_t disp_op,
    input  tag_t    disp_dest,
    input  tag_t    disp_src1_tag,
    input  word_t   disp_src1_data,
    input  logic    disp_src1_ready,
    input  tag_t    disp_src2_tag,
    input  word_t   disp_src2_data,
    input  logic    disp_src2_ready,
    output logic    disp_ready,
    input  logic    alu_valid,
    input  tag_t    alu_tag,
    input  word_t   alu_data,
    input  logic    load_valid,
    input  tag_t    load_tag,
    input  word_t   load_data,
    output logic    issue_valid,
    output div_op_t issue_op,
    output tag_t    issue_dest,
    output word_t   issue_a,
    output word_t   issue_b,
    input  logic    issue_ready
);

    wakeup_t [`RS_NUM_WAKEUP-1:0] wakeup;
    operand_t                     src1;
    operand_t                     src2;
    issue_t                       issue_data;

    assign wakeup[0] = '{valid: alu_valid, tag: alu_tag, data: alu_data};    // arithmetic bus
    assign wakeup[1] = '{valid: load_valid, tag: load_tag, data: load_data}; // load bus

    assign src1 = '{ready: disp_src1_ready, tag: disp_src1_tag, data: disp_src1_data};
    assign src2 = '{ready: disp_src2_ready, tag: disp_src2_tag, data: disp_src2_data};

    rs_write_if wr_bus ();
    rs_issue_if iss_bus ();

    rs_dispatch u_dispatch (
        .clk        (clk),
        .reset      (reset),
        .disp_valid (disp_valid),
        .disp_op    (disp_op),
        .disp_dest  (disp_dest),
        .disp_src1  (src1),
        .disp_src2  (src2),
        .wakeup     (wakeup),
        .disp_ready (disp_ready),
        .wr         (wr_bus)
    );

    rs_entry_array u_entries (
        .clk    (clk),
        .reset  (reset),
        .wakeup (wakeup),
        .wr     (wr_bus),
        .iss    (iss_bus)
    );

    rs_issue_select u_select (
        .clk         (clk),
        .reset       (reset),
        .iss         (iss_bus),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue_data  (issue_data)
    );

    assign issue_op   = issue_data.op;
    assign issue_dest = issue_data.dest;
    assign issue_a    = issue_data.a;
    assign issue_b    = issue_data.b;

endmodule

// ==== tests/div_rs_tb.sv ====
`timescale 1ns/1ps
`include "rs_config.svh"

module div_rs_tb import rs_pkg::*; ();

    localparam int PERIOD = 40;
    localparam int NTAGS  = 1 << `RS_TAG_W;
    // reset, ready, wakeup, bypass, full, stall
    localparam int RUN_CYCLES  = 10 + 40 + 60 + 30 + 80 + 200;
    localparam int WATCHDOG_NS = (RUN_CYCLES + 100) * PERIOD;

    logic    clk;
    logic    reset;
    logic    disp_valid;
    div_op_t disp_op;
    tag_t    disp_dest;
    tag_t    disp_src1_tag;
    word_t   disp_src1_data;
    logic    disp_src1_ready;
    tag_t    disp_src2_tag;
    word_t   disp_src2_data;
    logic    disp_src2_ready;
    logic    disp_ready;
    logic    alu_valid;
    tag_t    alu_tag;
    word_t   alu_data;
    logic    load_valid;
    tag_t    load_tag;
    word_t   load_data;
    logic    issue_valid;
    div_op_t issue_op;
    tag_t    issue_dest;
    word_t   issue_a;
    word_t   issue_b;
    logic    issue_ready;

    // reference model, indexed by destination tag
    bit      pending [NTAGS];
    bit      wait1 [NTAGS];
    bit      wait2 [NTAGS];
    tag_t    wtag1 [NTAGS];
    tag_t    wtag2 [NTAGS];
    div_op_t exp_op [NTAGS];
    word_t   exp_a [NTAGS];
    word_t   exp_b [NTAGS];
    int      in_flight = 0; // dispatched, not yet transferred
    int      arr_count;
    int      errors = 0;
    int      tests_done = 0;
    int      seed = 66;
    tag_t    next_dest = 8'h01;
    tag_t    next_src = 8'h80;

    div_op_t     exp_op_cur;
    word_t       exp_a_cur;
    word_t       exp_b_cur;
    logic        woken_cur;
    logic [75:0] issue_payload;
    logic [75:0] prev_payload;

    div_rs UUT (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    function automatic operand_t ready_src();
        operand_t s;
        s.ready = 1'b1;
        s.tag   = '0;
        s.data  = $random(seed);
        return s;
    endfunction

    function automatic operand_t waiting_src(input tag_t t);
        operand_t s;
        s.ready = 1'b0;
        s.tag   = t;
        s.data  = $random(seed); // stale, must be replaced
        return s;
    endfunction

    function automatic div_op_t rand_op();
        logic [31:0] r;
        r = $random(seed);
        return div_op_t'({2'b00, r[1:0]});
    endfunction

    function automatic tag_t new_src();
        next_src = next_src + 8'd1;
        return next_src;
    endfunction

    function automatic void capture(input int t, input logic v, input tag_t tag, input word_t d);
        if (v && wait1[t] && wtag1[t] == tag) begin
            exp_a[t] = d;
            wait1[t] = 1'b0;
        end
        if (v && wait2[t] && wtag2[t] == tag) begin
            exp_b[t] = d;
            wait2[t] = 1'b0;
        end
    endfunction

    always @(posedge clk) begin
        if (!reset) begin
            if (issue_valid && issue_ready) begin
                pending[issue_dest] = 1'b0;
                in_flight = in_flight - 1;
            end
            if (disp_valid && disp_ready) begin
                pending[disp_dest] = 1'b1;
                exp_op[disp_dest]  = disp_op;
                exp_a[disp_dest]   = disp_src1_data;
                exp_b[disp_dest]   = disp_src2_data;
                wait1[disp_dest]   = !disp_src1_ready;
                wait2[disp_dest]   = !disp_src2_ready;
                wtag1[disp_dest]   = disp_src1_tag;
                wtag2[disp_dest]   = disp_src2_tag;
                in_flight = in_flight + 1;
            end
            for (int t = 0; t < NTAGS; t++) begin
                if (pending[t]) begin // covers same-cycle bypass too
                    capture(t, alu_valid, alu_tag, alu_data);
                    capture(t, load_valid, load_tag, load_data);
                end
            end
        end
    end

    assign arr_count     = in_flight - int'(issue_valid); // issue register holds one
    assign exp_op_cur    = exp_op[issue_dest];
    assign exp_a_cur     = exp_a[issue_dest];
    assign exp_b_cur     = exp_b[issue_dest];
    assign woken_cur     = !wait1[issue_dest] && !wait2[issue_dest];
    assign issue_payload = {issue_op, issue_dest, issue_a, issue_b};

    always @(posedge clk) prev_payload <= issue_payload;

    a_idle: assert property (@(posedge clk) disable iff (reset) in_flight == 0 |-> !issue_valid)
        else begin
            $display("CHECK FAILED issue_valid: got %h expected 0", $sampled(issue_valid));
            errors++;
        end
    a_disp_ready: assert property (@(posedge clk) disable iff (reset)
        disp_ready == (arr_count < `RS_DEPTH))
        else begin
            $display("CHECK FAILED disp_ready: got %h expected %h", $sampled(disp_ready),
                     $sampled(arr_count < `RS_DEPTH));
            errors++;
        end
    a_known: assert property (@(posedge clk) disable iff (reset)
        issue_valid && issue_ready |-> pending[issue_dest])
        else begin
            $display("ERROR: tag %h issued twice or never dispatched", $sampled(issue_dest));
            errors++;
        end
    a_woken: assert property (@(posedge clk) disable iff (reset)
        issue_valid && issue_ready |-> woken_cur)
        else begin
            $display("ERROR: tag %h issued before its source was broadcast", $sampled(issue_dest));
            errors++;
        end
    a_op: assert property (@(posedge clk) disable iff (reset)
        issue_valid && issue_ready |-> issue_op == exp_op_cur)
        else begin
            $display("CHECK FAILED issue_op: got %h expected %h", $sampled(issue_op),
                     $sampled(exp_op_cur));
            errors++;
        end
    a_data_a: assert property (@(posedge clk) disable iff (reset)
        issue_valid && issue_ready |-> issue_a == exp_a_cur)
        else begin
            $display("CHECK FAILED issue_a: got %h expected %h", $sampled(issue_a),
                     $sampled(exp_a_cur));
            errors++;
        end
    a_data_b: assert property (@(posedge clk) disable iff (reset)
        issue_valid && issue_ready |-> issue_b == exp_b_cur)
        else begin
            $display("CHECK FAILED issue_b: got %h expected %h", $sampled(issue_b),
                     $sampled(exp_b_cur));
            errors++;
        end
    a_hold: assert property (@(posedge clk) disable iff (reset)
        issue_valid && !issue_ready |=> issue_valid && issue_payload == prev_payload)
        else begin
            $display("CHECK FAILED issue_payload: got %h expected %h", $sampled(issue_payload),
                     $sampled(prev_payload));
            errors++;
        end

    task automatic dispatch_op(input div_op_t op, input operand_t s1, input operand_t s2);
        disp_valid      <= 1'b1;
        disp_op         <= op;
        disp_dest       <= next_dest;
        disp_src1_ready <= s1.ready;
        disp_src1_tag   <= s1.tag;
        disp_src1_data  <= s1.data;
        disp_src2_ready <= s2.ready;
        disp_src2_tag   <= s2.tag;
        disp_src2_data  <= s2.data;
        do @(posedge clk); while (!disp_ready);
        disp_valid <= 1'b0;
        next_dest = next_dest + 8'd1;
    endtask

    task automatic drive_bcast(input int bus, input tag_t t, input word_t d);
        if (bus == 0) begin
            alu_valid <= 1'b1;
            alu_tag   <= t;
            alu_data  <= d;
        end else begin
            load_valid <= 1'b1;
            load_tag   <= t;
            load_data  <= d;
        end
    endtask

    task automatic clear_bcast();
        alu_valid  <= 1'b0;
        load_valid <= 1'b0;
    endtask

    task automatic broadcast(input int bus, input tag_t t, input word_t d);
        drive_bcast(bus, t, d);
        @(posedge clk);
        clear_bcast();
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (in_flight != 0 && n < 100) begin
            @(posedge clk);
            n++;
        end
        if (in_flight != 0) begin
            $display("ERROR: %0d operations never issued", in_flight);
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        tests_done++;
        $display("test %s finished, %0d errors so far", name, errors);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired after %0d ns", WATCHDOG_NS);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        tag_t        w [5];
        logic [31:0] r;
        reset = 1'b1;
        disp_valid = 1'b0;
        disp_op = DIV;
        disp_dest = '0;
        disp_src1_tag = '0;
        disp_src1_data = '0;
        disp_src1_ready = 1'b0;
        disp_src2_tag = '0;
        disp_src2_data = '0;
        disp_src2_ready = 1'b0;
        alu_valid = 1'b0;
        alu_tag = '0;
        alu_data = '0;
        load_valid = 1'b0;
        load_tag = '0;
        load_data = '0;
        issue_ready = 1'b0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        issue_ready <= 1'b1;
        repeat (8) dispatch_op(rand_op(), ready_src(), ready_src());
        wait_drain();
        report_test("ready_at_dispatch");

        for (int i = 0; i < 5; i++) w[i] = new_src();
        dispatch_op(rand_op(), waiting_src(w[0]), ready_src());
        dispatch_op(rand_op(), ready_src(), waiting_src(w[1]));
        dispatch_op(rand_op(), waiting_src(w[2]), waiting_src(w[3]));
        dispatch_op(rand_op(), waiting_src(w[4]), waiting_src(w[4])); // one producer, both sides
        repeat (5) @(posedge clk);
        broadcast(0, w[0], $random(seed));
        broadcast(1, w[1], $random(seed));
        drive_bcast(0, w[2], $random(seed));
        drive_bcast(1, w[3], $random(seed));
        @(posedge clk);
        clear_bcast();
        repeat (3) @(posedge clk);
        broadcast(1, w[4], $random(seed));
        wait_drain();
        report_test("wakeup");

        for (int i = 0; i < 4; i++) w[i] = new_src();
        drive_bcast(0, w[0], $random(seed));
        dispatch_op(rand_op(), waiting_src(w[0]), ready_src());
        clear_bcast();
        drive_bcast(1, w[1], $random(seed));
        dispatch_op(rand_op(), ready_src(), waiting_src(w[1]));
        clear_bcast();
        drive_bcast(0, w[2], $random(seed));
        drive_bcast(1, w[3], $random(seed));
        dispatch_op(rand_op(), waiting_src(w[2]), waiting_src(w[3]));
        clear_bcast();
        wait_drain();
        report_test("bypass");

        // station plus issue register fill up
        issue_ready <= 1'b0;
        repeat (`RS_DEPTH + 1) dispatch_op(rand_op(), ready_src(), ready_src());
        repeat (3) @(posedge clk);
        issue_ready <= 1'b1;
        @(posedge clk);
        issue_ready <= 1'b0;
        repeat (3) @(posedge clk);
        issue_ready <= 1'b1;
        wait_drain();
        report_test("full_station");

        fork
            repeat (30) dispatch_op(rand_op(), ready_src(), ready_src());
            repeat (80) begin
                r = $random(seed);
                issue_ready <= r[0];
                @(posedge clk);
            end
        join
        issue_ready <= 1'b1;
        wait_drain();
        report_test("stall");

        $display("tests run %0d, errors %0d", tests_done, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== div_rs.f ====
+incdir+rtl
rtl/rs_pkg.sv
rtl/rs_write_if.sv
rtl/rs_issue_if.sv
rtl/rs_dispatch.sv
rtl/rs_entry_array.sv
rtl/rs_issue_select.sv
rtl/div_rs.sv
tests/div_rs_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile div_rs with its testbench under Verilator, run it and scan the log.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f div_rs.f --top-module div_rs_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/Vdiv_rs_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
    exit 1
fi
if ! grep -q "PASS: all tests" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
